// ==== Makefile ====
TOP := mpmc_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f mpmc.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// ==== hw/mpmc_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module mpmc_arbiter (
	input wire clk,
	input wire rst,
	input wire [mpmc_cfg_pkg::NCH-1:0] req_valid,
	input wire busy,
	output logic [mpmc_cfg_pkg::CHW-1:0] grant,
	output logic grant_valid
);
	import mpmc_cfg_pkg::*;

	// Channel served last, the search for the next grant starts after it
	logic [CHW-1:0] last;
	logic [CHW-1:0] pick;
	logic [CHW-1:0] cand;

	// Walk the channels from farthest to nearest after the last one served
	// so that the nearest requesting channel wins
	always_comb begin
		pick = last;
		cand = last;
		for (int i = NCH; i >= 1; i--) begin
			cand = last + CHW'(i);
			if (req_valid[cand])
				pick = cand;
		end
	end

	// While a request is in flight the grant stays on the channel being served
	assign grant = busy ? last : pick;
	assign grant_valid = !busy && (|req_valid);

	// Start so that channel 0 is the first one looked at after reset
	always_ff @(posedge clk) begin
		if (rst)
			last <= CHW'(NCH - 1);
		else if (grant_valid)
			last <= pick;
	end

endmodule

`default_nettype wire

// ==== hw/mpmc_cfg_pkg.sv ====
`default_nettype none

package mpmc_cfg_pkg;

	// ====================
	// Controller sizes
	// ====================

	localparam int NCH = 4;
	localparam int CHW = $clog2(NCH);
	localparam int NAR = 2;
	localparam int AW = 32;
	localparam int SW = 32;
	localparam int MAX_STRIPS = 4;
	localparam int LENW = $clog2(MAX_STRIPS);
	// A full line as the channels see it, four strips wide
	localparam int LW = SW * MAX_STRIPS;
	localparam int OFSW = $clog2(LW / 8);
	localparam int LINEW = AW - OFSW;

	// The same address word is read as a byte address or as line and offset
	typedef union packed {
		logic [AW-1:0] raw;
		struct packed {
			logic [LINEW-1:0] line;
			logic [OFSW-1:0] offset;
		} f;
	} mem_adr_u;

	// Response status returned with every channel response
	localparam int STW = 2;
	localparam logic [STW-1:0] ST_OK = 2'd0;
	localparam logic [STW-1:0] ST_SC_FAIL = 2'd1;
	localparam logic [STW-1:0] ST_TIMEOUT = 2'd2;

endpackage

`default_nettype wire

// ==== hw/mpmc_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module mpmc_datapath (
	input wire clk,
	input wire rst,
	input wire mpmc_fsm_pkg::mpmc_state_e state,
	input wire [mpmc_cfg_pkg::CHW-1:0] grant,
	input wire [mpmc_cfg_pkg::NCH-1:0] ch_we,
	input wire [mpmc_cfg_pkg::NCH-1:0] ch_rsv,
	input wire [mpmc_cfg_pkg::NCH-1:0] ch_cr,
	input wire [mpmc_cfg_pkg::NCH-1:0][mpmc_cfg_pkg::AW-1:0] ch_adr,
	input wire [mpmc_cfg_pkg::NCH-1:0][mpmc_cfg_pkg::LENW-1:0] ch_len,
	input wire [mpmc_cfg_pkg::NCH-1:0][mpmc_cfg_pkg::LW-1:0] ch_wdata,
	input wire app_cmd_ready,
	input wire app_wdf_ready,
	input wire app_rd_valid,
	input wire [mpmc_cfg_pkg::SW-1:0] app_rd_data,
	output logic we,
	output logic cr,
	output logic rsv,
	output mpmc_cfg_pkg::mem_adr_u adr,
	output logic wdf_done,
	output logic cmd_done,
	output logic rsp_done,
	output logic app_cmd_valid,
	output logic app_cmd_we,
	output logic [mpmc_cfg_pkg::AW-1:0] app_adr,
	output logic app_wdf_valid,
	output logic [mpmc_cfg_pkg::SW-1:0] app_wdf_data,
	output logic [mpmc_cfg_pkg::LW-1:0] rdata
);
	import mpmc_cfg_pkg::*;
	import mpmc_fsm_pkg::*;

	// Byte address step between two strips
	localparam int SSH = $clog2(SW / 8);

	logic [LENW-1:0] len_r;
	logic [LW-1:0] wdata_r;
	logic [LENW-1:0] wdf_cnt;
	logic [LENW-1:0] cmd_cnt;
	logic [LENW-1:0] rsp_cnt;
	logic wdf_fire;
	logic cmd_fire;
	logic rd_fire;

	// Sampled every IDLE cycle, the last one is the cycle the grant is taken
	always_ff @(posedge clk) begin
		if (rst) begin
			we <= 1'b0;
			cr <= 1'b0;
			rsv <= 1'b0;
		end else if (state == IDLE) begin
			we <= ch_we[grant];
			cr <= ch_cr[grant];
			rsv <= ch_rsv[grant];
		end
	end

	always_ff @(posedge clk) begin
		if (state == IDLE) begin
			adr.raw <= ch_adr[grant];
			len_r <= ch_len[grant];
			wdata_r <= ch_wdata[grant];
		end
	end

	// Memory ports follow the state, the counters pick the strip
	assign app_wdf_valid = (state == WRITE_DATA0);
	assign app_wdf_data = wdata_r[wdf_cnt * SW +: SW];
	assign app_cmd_valid = (state == WRITE_DATA2) || (state == READ_DATA1);
	assign app_cmd_we = we;
	assign app_adr = adr.raw + (AW'(cmd_cnt) << SSH);

	assign wdf_fire = app_wdf_valid && app_wdf_ready;
	assign cmd_fire = app_cmd_valid && app_cmd_ready;
	// Strips that turn up outside the read phases belong to an abandoned read
	assign rd_fire = app_rd_valid && (state == READ_DATA1 || state == READ_DATA2);

	assign wdf_done = wdf_fire && (wdf_cnt == len_r);
	assign cmd_done = cmd_fire && (cmd_cnt == len_r);
	assign rsp_done = rd_fire && (rsp_cnt == len_r);

	always_ff @(posedge clk) begin
		if (rst || state == IDLE) begin
			wdf_cnt <= '0;
			cmd_cnt <= '0;
			rsp_cnt <= '0;
		end else begin
			if (wdf_fire)
				wdf_cnt <= wdf_cnt + 1'b1;
			if (cmd_fire)
				cmd_cnt <= cmd_cnt + 1'b1;
			if (rd_fire)
				rsp_cnt <= rsp_cnt + 1'b1;
		end
	end

	// Read strips land in request order, strip 0 in the low word
	always_ff @(posedge clk) begin
		if (rd_fire)
			rdata[rsp_cnt * SW +: SW] <= app_rd_data;
	end

endmodule

`default_nettype wire

// ==== hw/mpmc_fsm_pkg.sv ====
`default_nettype none

package mpmc_fsm_pkg;

	// Sequencer states, in the order a request walks through them
	typedef enum logic [3:0] {
		IDLE,
		PRESET1,
		PRESET2,
		PRESET3,
		WRITE_DATA0,
		WRITE_DATA1,
		WRITE_DATA2,
		WRITE_DATA3,
		READ_DATA0,
		READ_DATA1,
		READ_DATA2,
		WAIT_NACK
	} mpmc_state_e;

	// Cycles the sequencer may spend in the memory phases before giving up
	localparam int TIMEOUT_CYCLES = 64;

endpackage

`default_nettype wire

// ==== hw/mpmc_resv.sv ====
`timescale 1ns/1ps
`default_nettype none

module mpmc_resv (
	input wire clk,
	input wire rst,
	input wire set,
	input wire clear_wr,
	input wire [mpmc_cfg_pkg::CHW-1:0] ch,
	input wire mpmc_cfg_pkg::mem_adr_u adr,
	output logic match
);
	import mpmc_cfg_pkg::*;

	localparam int IDXW = (NAR > 1) ? $clog2(NAR) : 1;

	logic [NAR-1:0] rsv_vld;
	logic [NAR-1:0][CHW-1:0] rsv_ch;
	logic [NAR-1:0][LINEW-1:0] rsv_line;
	logic [IDXW-1:0] repl_ptr;
	logic own_hit;
	logic [IDXW-1:0] own_idx;
	logic free_hit;
	logic [IDXW-1:0] free_idx;
	logic [IDXW-1:0] slot;

	// Look for an entry this channel already owns and for a free entry
	// Lowest index wins in both searches
	always_comb begin
		own_hit = 1'b0;
		own_idx = '0;
		free_hit = 1'b0;
		free_idx = '0;
		match = 1'b0;
		for (int i = NAR - 1; i >= 0; i--) begin
			if (rsv_vld[i] && rsv_ch[i] == ch) begin
				own_hit = 1'b1;
				own_idx = IDXW'(i);
			end
			if (!rsv_vld[i]) begin
				free_hit = 1'b1;
				free_idx = IDXW'(i);
			end
			if (rsv_vld[i] && rsv_ch[i] == ch && rsv_line[i] == adr.f.line)
				match = 1'b1;
		end
	end

	// A channel keeps at most one entry, otherwise a free one is taken,
	// and only when the table is full is an entry evicted
	assign slot = own_hit ? own_idx : (free_hit ? free_idx : repl_ptr);

	always_ff @(posedge clk) begin
		if (rst) begin
			rsv_vld <= '0;
			repl_ptr <= '0;
		end else begin
			// A finished write to a line kills every reservation on it
			if (clear_wr)
				for (int i = 0; i < NAR; i++)
					if (rsv_vld[i] && rsv_line[i] == adr.f.line)
						rsv_vld[i] <= 1'b0;
			if (set) begin
				rsv_vld[slot] <= 1'b1;
				if (!own_hit && !free_hit)
					repl_ptr <= (repl_ptr == IDXW'(NAR - 1)) ? '0 : repl_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (set) begin
			rsv_ch[slot] <= ch;
			rsv_line[slot] <= adr.f.line;
		end
	end

endmodule

`default_nettype wire

// ==== hw/mpmc_state_machine.sv ====
`timescale 1ns/1ps
`default_nettype none

module mpmc_state_machine (
	input wire clk,
	input wire rst,
	input wire grant_valid,
	input wire we,
	input wire cr,
	input wire resv_match,
	input wire wdf_done,
	input wire cmd_done,
	input wire rsp_done,
	input wire resp_ready,
	output mpmc_fsm_pkg::mpmc_state_e state,
	output logic [mpmc_cfg_pkg::STW-1:0] status
);
	import mpmc_cfg_pkg::*;
	import mpmc_fsm_pkg::*;

	localparam int WDW = $clog2(TIMEOUT_CYCLES + 1);

	mpmc_state_e next_state;
	logic [WDW-1:0] wd_cnt;
	logic timeout;
	logic sc_refused;

	// ====================
	// Watchdog
	// ====================

	// Only the memory phases are timed, waiting on the channel is not
	always_ff @(posedge clk) begin
		if (rst)
			wd_cnt <= '0;
		else if (state == IDLE || state == WAIT_NACK)
			wd_cnt <= '0;
		else
			wd_cnt <= wd_cnt + 1'b1;
	end

	// Fires on the last allowed cycle so the next cycle is already WAIT_NACK
	// The count still holds its old value in the first WAIT_NACK cycle, so only timed states fire
	assign timeout = (wd_cnt == WDW'(TIMEOUT_CYCLES - 1)) &&
		(state != IDLE) && (state != WAIT_NACK);

	// A conditional store without a live reservation never reaches memory
	assign sc_refused = cr && !resv_match;

	// ====================
	// Sequencer
	// ====================

	always_comb begin
		next_state = state;
		case (state)
			IDLE:
				if (grant_valid)
					next_state = PRESET1;
			// Address and data settle in the datapath during the presets
			PRESET1:
				next_state = PRESET2;
			PRESET2:
				next_state = PRESET3;
			// PRESET3 decides between the write path, the read path and a refusal
			PRESET3:
				if (sc_refused)
					next_state = WAIT_NACK;
				else if (we)
					next_state = WRITE_DATA0;
				else
					next_state = READ_DATA0;
			// All write strips go into the data FIFO before any command
			WRITE_DATA0:
				if (wdf_done)
					next_state = WRITE_DATA1;
			WRITE_DATA1:
				next_state = WRITE_DATA2;
			WRITE_DATA2:
				if (cmd_done)
					next_state = WRITE_DATA3;
			WRITE_DATA3:
				next_state = WAIT_NACK;
			READ_DATA0:
				next_state = READ_DATA1;
			// Read commands may still be going out when the first strips return
			READ_DATA1:
				if (cmd_done)
					next_state = READ_DATA2;
			READ_DATA2:
				if (rsp_done)
					next_state = WAIT_NACK;
			WAIT_NACK:
				if (resp_ready)
					next_state = IDLE;
			default:
				next_state = IDLE;
		endcase
		// A hung memory phase is cut short and reported to the channel
		if (timeout)
			next_state = WAIT_NACK;
	end

	always_ff @(posedge clk) begin
		if (rst)
			state <= IDLE;
		else
			state <= next_state;
	end

	// Status is fixed by the time WAIT_NACK shows it and stays put there
	always_ff @(posedge clk) begin
		if (rst)
			status <= ST_OK;
		else if (timeout)
			status <= ST_TIMEOUT;
		else if (state == IDLE && grant_valid)
			status <= ST_OK;
		else if (state == PRESET3 && sc_refused)
			status <= ST_SC_FAIL;
	end

endmodule

`default_nettype wire

// ==== hw/mpmc_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mpmc_top (
	input wire clk,
	input wire rst,
	input wire [mpmc_cfg_pkg::NCH-1:0] ch_req_valid,
	input wire [mpmc_cfg_pkg::NCH-1:0] ch_we,
	input wire [mpmc_cfg_pkg::NCH-1:0] ch_rsv,
	input wire [mpmc_cfg_pkg::NCH-1:0] ch_cr,
	input wire [mpmc_cfg_pkg::NCH-1:0][mpmc_cfg_pkg::AW-1:0] ch_adr,
	input wire [mpmc_cfg_pkg::NCH-1:0][mpmc_cfg_pkg::LENW-1:0] ch_len,
	input wire [mpmc_cfg_pkg::NCH-1:0][mpmc_cfg_pkg::LW-1:0] ch_wdata,
	output logic [mpmc_cfg_pkg::NCH-1:0] ch_req_ready,
	output logic [mpmc_cfg_pkg::NCH-1:0] ch_resp_valid,
	output logic [mpmc_cfg_pkg::STW-1:0] ch_resp_status,
	output logic [mpmc_cfg_pkg::LW-1:0] ch_rdata,
	input wire [mpmc_cfg_pkg::NCH-1:0] ch_resp_ready,
	output logic app_cmd_valid,
	output logic app_cmd_we,
	output logic [mpmc_cfg_pkg::AW-1:0] app_adr,
	input wire app_cmd_ready,
	output logic app_wdf_valid,
	output logic [mpmc_cfg_pkg::SW-1:0] app_wdf_data,
	input wire app_wdf_ready,
	input wire app_rd_valid,
	input wire [mpmc_cfg_pkg::SW-1:0] app_rd_data
);
	import mpmc_cfg_pkg::*;
	import mpmc_fsm_pkg::*;

	logic [CHW-1:0] grant;
	logic grant_valid;
	logic busy;
	mpmc_state_e state;
	logic [STW-1:0] status;
	logic we_l;
	logic cr_l;
	logic rsv_l;
	mem_adr_u adr_l;
	logic wdf_done;
	logic cmd_done;
	logic rsp_done;
	logic resv_match;
	logic resv_set;
	logic resv_clr;
	logic resp_ready;
	logic [NCH-1:0] grant_oh;

	// ====================
	// Channel handshakes
	// ====================

	assign busy = (state != IDLE);
	assign grant_oh = NCH'(1) << grant;
	// The request is taken in the IDLE cycle that shows a grant
	assign ch_req_ready = (state == IDLE && grant_valid) ? grant_oh : '0;
	assign ch_resp_valid = (state == WAIT_NACK) ? grant_oh : '0;
	assign resp_ready = ch_resp_ready[grant];
	assign ch_resp_status = status;

	// A reservation is made once the reserving read has been delivered,
	// and any write that reached memory drops reservations on its line
	assign resv_set = (state == WAIT_NACK) && resp_ready && rsv_l && (status == ST_OK);
	assign resv_clr = (state == WRITE_DATA3);

	mpmc_arbiter u_arbiter (
		.clk(clk),
		.rst(rst),
		.req_valid(ch_req_valid),
		.busy(busy),
		.grant(grant),
		.grant_valid(grant_valid)
	);

	mpmc_state_machine u_state_machine (
		.clk(clk),
		.rst(rst),
		.grant_valid(grant_valid),
		.we(we_l),
		.cr(cr_l),
		.resv_match(resv_match),
		.wdf_done(wdf_done),
		.cmd_done(cmd_done),
		.rsp_done(rsp_done),
		.resp_ready(resp_ready),
		.state(state),
		.status(status)
	);

	mpmc_datapath u_datapath (
		.clk(clk),
		.rst(rst),
		.state(state),
		.grant(grant),
		.ch_we(ch_we),
		.ch_rsv(ch_rsv),
		.ch_cr(ch_cr),
		.ch_adr(ch_adr),
		.ch_len(ch_len),
		.ch_wdata(ch_wdata),
		.app_cmd_ready(app_cmd_ready),
		.app_wdf_ready(app_wdf_ready),
		.app_rd_valid(app_rd_valid),
		.app_rd_data(app_rd_data),
		.we(we_l),
		.cr(cr_l),
		.rsv(rsv_l),
		.adr(adr_l),
		.wdf_done(wdf_done),
		.cmd_done(cmd_done),
		.rsp_done(rsp_done),
		.app_cmd_valid(app_cmd_valid),
		.app_cmd_we(app_cmd_we),
		.app_adr(app_adr),
		.app_wdf_valid(app_wdf_valid),
		.app_wdf_data(app_wdf_data),
		.rdata(ch_rdata)
	);

	mpmc_resv u_resv (
		.clk(clk),
		.rst(rst),
		.set(resv_set),
		.clear_wr(resv_clr),
		.ch(grant),
		.adr(adr_l),
		.match(resv_match)
	);

endmodule

`default_nettype wire

// ==== mpmc.f ====
hw/mpmc_cfg_pkg.sv
hw/mpmc_fsm_pkg.sv
hw/mpmc_arbiter.sv
hw/mpmc_resv.sv
hw/mpmc_state_machine.sv
hw/mpmc_datapath.sv
hw/mpmc_top.sv
verification/mpmc_checker.sv
verification/mpmc_tb.sv

// ==== verification/mpmc_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module mpmc_checker (
	input wire clk,
	input wire rst,
	input wire [mpmc_cfg_pkg::NCH-1:0] ch_req_valid,
	input wire [mpmc_cfg_pkg::NCH-1:0] ch_req_ready,
	input wire [mpmc_cfg_pkg::NCH-1:0] ch_resp_valid,
	input wire [mpmc_cfg_pkg::NCH-1:0] ch_resp_ready,
	input wire [mpmc_cfg_pkg::STW-1:0] ch_resp_status,
	input wire [mpmc_cfg_pkg::LW-1:0] ch_rdata,
	input wire app_cmd_valid,
	input wire app_cmd_ready,
	input wire [mpmc_cfg_pkg::AW-1:0] app_adr,
	input wire app_wdf_valid
);
	import mpmc_cfg_pkg::*;

	// Grants handed to other channels while this one keeps its valid up
	logic [NCH-1:0][2:0] wait_cnt;
	logic starve;

	// ====================
	// Fairness
	// ====================

	always_ff @(posedge clk) begin
		if (rst) begin
			wait_cnt <= '0;
		end else begin
			for (int i = 0; i < NCH; i++) begin
				// Being served or dropping the request ends the wait
				if (!ch_req_valid[i] || ch_req_ready[i])
					wait_cnt[i] <= '0;
				else if (|ch_req_ready)
					wait_cnt[i] <= wait_cnt[i] + 1'b1;
			end
		end
	end

	always_comb begin
		starve = 1'b0;
		for (int i = 0; i < NCH; i++)
			starve = starve || (wait_cnt[i] > 3'(NCH - 1));
	end

	a_fair: assert property (@(posedge clk) disable iff (rst) !starve)
		else $error("A channel was passed over by more than NCH-1 grants");

	// ====================
	// Handshake stability
	// ====================

	// A response not yet taken keeps its valid, status and data
	a_resp_hold: assert property (@(posedge clk) disable iff (rst)
		(|(ch_resp_valid & ~ch_resp_ready)) |=>
		($stable(ch_resp_valid) && $stable(ch_resp_status) && $stable(ch_rdata)))
		else $error("Channel response changed before it was accepted");

	// A memory command waits with the same address until memory takes it
	a_cmd_hold: assert property (@(posedge clk) disable iff (rst)
		(app_cmd_valid && !app_cmd_ready) |=> (app_cmd_valid && $stable(app_adr)))
		else $error("Memory command dropped or changed address while stalled");

	// Nothing handshakes while reset is held
	a_reset_quiet: assert property (@(posedge clk)
		(rst && $past(rst)) |->
		(!(|ch_req_ready) && !(|ch_resp_valid) && !app_cmd_valid && !app_wdf_valid))
		else $error("An output was active during reset");

endmodule

`default_nettype wire

// ==== verification/mpmc_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mpmc_tb;
	import mpmc_cfg_pkg::*;

	localparam int MEM_WORDS = 1024;
	localparam int WAIT_LIMIT = 1000;

	logic clk;
	logic rst;
	logic [NCH-1:0] ch_req_valid;
	logic [NCH-1:0] ch_we;
	logic [NCH-1:0] ch_rsv;
	logic [NCH-1:0] ch_cr;
	logic [NCH-1:0][AW-1:0] ch_adr;
	logic [NCH-1:0][LENW-1:0] ch_len;
	logic [NCH-1:0][LW-1:0] ch_wdata;
	logic [NCH-1:0] ch_req_ready;
	logic [NCH-1:0] ch_resp_valid;
	logic [STW-1:0] ch_resp_status;
	logic [LW-1:0] ch_rdata;
	logic [NCH-1:0] ch_resp_ready;
	logic app_cmd_valid;
	logic app_cmd_we;
	logic [AW-1:0] app_adr;
	logic app_cmd_ready;
	logic app_wdf_valid;
	logic [SW-1:0] app_wdf_data;
	logic app_wdf_ready;
	logic app_rd_valid;
	logic [SW-1:0] app_rd_data;

	// Memory behind the app interface and the model the results are checked against
	logic [SW-1:0] mem [MEM_WORDS];
	logic [SW-1:0] ref_mem [MEM_WORDS];
	logic [SW-1:0] wdf_q [$];
	logic [SW-1:0] rd_q [$];
	int rd_due [$];
	logic drop_rd;
	int unsigned seed_val;

	mpmc_top u_dut (.*);

	bind mpmc_top mpmc_checker u_checker (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ====================
	// Helpers
	// ====================

	function automatic logic [SW-1:0] fill_word(input logic [AW-1:0] a);
		return (a * 32'h9e3779b1) ^ 32'h5ac30f96;
	endfunction

	function automatic logic [9:0] mem_index(input logic [AW-1:0] a);
		return a[11:2];
	endfunction

	// Lines used by the tests sit above address 0x100, one per number
	function automatic logic [AW-1:0] line_adr(input int n);
		return 32'h100 + 32'(n) * 16;
	endfunction

	function automatic logic [LW-1:0] expect_line(input logic [AW-1:0] adr,
			input logic [LENW-1:0] len);
		logic [LW-1:0] d;
		d = '0;
		for (int s = 0; s <= int'(len); s++)
			d[s*SW +: SW] = ref_mem[mem_index(adr + 32'(s) * 4)];
		return d;
	endfunction

	// Strips past the request length are left over from older reads
	function automatic logic [LW-1:0] mask_strips(input logic [LW-1:0] d,
			input logic [LENW-1:0] len);
		logic [LW-1:0] m;
		m = '0;
		for (int s = 0; s <= int'(len); s++)
			m[s*SW +: SW] = d[s*SW +: SW];
		return m;
	endfunction

	function automatic logic [LW-1:0] rand_line();
		return {$urandom, $urandom, $urandom, $urandom};
	endfunction

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("*** FAILED ***");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [LW-1:0] exp,
			input logic [LW-1:0] act);
		assert (act === exp)
		else fail_run($sformatf("ERR %s: expected %0h, actual %0h", name, exp, act));
	endtask

	task automatic commit_write(input logic [AW-1:0] adr, input logic [LENW-1:0] len,
			input logic [LW-1:0] data);
		for (int s = 0; s <= int'(len); s++)
			ref_mem[mem_index(adr + 32'(s) * 4)] = data[s*SW +: SW];
	endtask

	// ====================
	// Channel driver
	// ====================

	// Entered and left 1 ns after a rising edge
	task automatic issue_req(input int ch, input logic we, input logic rsv, input logic cr,
			input logic [AW-1:0] adr, input logic [LENW-1:0] len, input logic [LW-1:0] wdata,
			output logic [STW-1:0] st, output logic [LW-1:0] rd);
		logic [CHW-1:0] c;
		logic done;
		int n;
		c = CHW'(ch);
		ch_req_valid[c] = 1'b1;
		ch_we[c] = we;
		ch_rsv[c] = rsv;
		ch_cr[c] = cr;
		ch_adr[c] = adr;
		ch_len[c] = len;
		ch_wdata[c] = wdata;
		done = 1'b0;
		n = 0;
		while (!done) begin
			@(negedge clk);
			if (ch_req_ready[c]) begin
				done = 1'b1;
			end else begin
				n++;
				if (n > WAIT_LIMIT)
					fail_run($sformatf("Request on channel %0d was never accepted", ch));
			end
			@(posedge clk);
			#1;
		end
		ch_req_valid[c] = 1'b0;
		// Random ready on the response side to stall the WAIT_NACK state
		done = 1'b0;
		n = 0;
		st = '0;
		rd = '0;
		while (!done) begin
			ch_resp_ready[c] = 1'($urandom % 2);
			@(negedge clk);
			if (ch_resp_valid[c] && ch_resp_ready[c]) begin
				done = 1'b1;
				st = ch_resp_status;
				rd = ch_rdata;
			end else begin
				n++;
				if (n > WAIT_LIMIT)
					fail_run($sformatf("No response arrived on channel %0d", ch));
			end
			@(posedge clk);
			#1;
		end
		ch_resp_ready[c] = 1'b0;
	endtask

	task automatic write_line(input string name, input int ch, input logic cr,
			input logic [AW-1:0] adr, input logic [LENW-1:0] len, input logic [LW-1:0] data,
			input logic [STW-1:0] exp_st);
		logic [STW-1:0] st;
		logic [LW-1:0] rd;
		issue_req(ch, 1'b1, 1'b0, cr, adr, len, data, st, rd);
		check_value({name, " status"}, LW'(exp_st), LW'(st));
		if (exp_st == ST_OK)
			commit_write(adr, len, data);
	endtask

	task automatic read_line(input string name, input int ch, input logic rsv,
			input logic [AW-1:0] adr, input logic [LENW-1:0] len, input logic [STW-1:0] exp_st);
		logic [STW-1:0] st;
		logic [LW-1:0] rd;
		issue_req(ch, 1'b0, rsv, 1'b0, adr, len, '0, st, rd);
		check_value({name, " status"}, LW'(exp_st), LW'(st));
		if (exp_st == ST_OK)
			check_value({name, " data"}, expect_line(adr, len), mask_strips(rd, len));
	endtask

	// Every length on a line of the channel's own, each written then read back
	task automatic write_read_ch(input int ch);
		string name;
		for (int l = 0; l < MAX_STRIPS; l++) begin
			name = $sformatf("write_read ch%0d len%0d", ch, l + 1);
			write_line(name, ch, 1'b0, line_adr(ch * 4 + l), LENW'(l), rand_line(), ST_OK);
			read_line(name, ch, 1'b0, line_adr(ch * 4 + l), LENW'(l), ST_OK);
		end
	endtask

	// ====================
	// Memory model
	// ====================

	initial begin : mem_model
		int cyc;
		app_cmd_ready = 1'b0;
		app_wdf_ready = 1'b0;
		app_rd_valid = 1'b0;
		app_rd_data = '0;
		for (int i = 0; i < MEM_WORDS; i++)
			mem[i] = fill_word(32'(i) << 2);
		cyc = 0;
		forever begin
			@(posedge clk);
			#1;
			cyc++;
			app_cmd_ready = ($urandom % 4) != 0;
			app_wdf_ready = ($urandom % 4) != 0;
			app_rd_valid = 1'b0;
			// Strips leave in order, a late head strip holds back the rest
			if (rd_q.size() > 0 && rd_due[0] <= cyc) begin
				app_rd_valid = 1'b1;
				app_rd_data = rd_q.pop_front();
				void'(rd_due.pop_front());
			end
			@(negedge clk);
			if (app_wdf_valid && app_wdf_ready)
				wdf_q.push_back(app_wdf_data);
			if (app_cmd_valid && app_cmd_ready) begin
				if (app_cmd_we) begin
					if (wdf_q.size() == 0)
						fail_run("Write command reached memory with no write data queued");
					mem[mem_index(app_adr)] = wdf_q.pop_front();
				end else if (!drop_rd) begin
					rd_q.push_back(mem[mem_index(app_adr)]);
					rd_due.push_back(cyc + 1 + int'($urandom % 4));
				end
			end
		end
	end

	// ====================
	// Test sequence
	// ====================

	initial begin
		seed_val = $urandom(32'hab3f46d7);
		rst = 1'b1;
		ch_req_valid = '0;
		ch_we = '0;
		ch_rsv = '0;
		ch_cr = '0;
		ch_adr = '0;
		ch_len = '0;
		ch_wdata = '0;
		ch_resp_ready = '0;
		drop_rd = 1'b0;
		for (int i = 0; i < MEM_WORDS; i++)
			ref_mem[i] = fill_word(32'(i) << 2);
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;

		// All four channels compete, which also exercises the arbiter
		fork
			write_read_ch(0);
			write_read_ch(1);
			write_read_ch(2);
			write_read_ch(3);
		join

		// Reserving read then conditional store by the same channel
		read_line("sc_reserve", 1, 1'b1, line_adr(16), 2'd3, ST_OK);
		write_line("sc_store", 1, 1'b1, line_adr(16), 2'd3, rand_line(), ST_OK);
		read_line("sc_verify", 1, 1'b0, line_adr(16), 2'd3, ST_OK);

		// Another channel's write in between kills the reservation
		read_line("sc_intervene_rsv", 2, 1'b1, line_adr(17), 2'd1, ST_OK);
		write_line("sc_intervene_wr", 3, 1'b0, line_adr(17), 2'd1, rand_line(), ST_OK);
		write_line("sc_intervene_sc", 2, 1'b1, line_adr(17), 2'd1, rand_line(), ST_SC_FAIL);
		read_line("sc_intervene_chk", 2, 1'b0, line_adr(17), 2'd1, ST_OK);

		// No reservation at all
		write_line("sc_no_rsv", 0, 1'b1, line_adr(18), 2'd2, rand_line(), ST_SC_FAIL);
		read_line("sc_no_rsv_chk", 0, 1'b0, line_adr(18), 2'd2, ST_OK);

		// Memory swallows one read so the watchdog has to end it
		drop_rd = 1'b1;
		read_line("timeout", 0, 1'b0, line_adr(19), 2'd3, ST_TIMEOUT);
		drop_rd = 1'b0;
		read_line("after_timeout", 0, 1'b0, line_adr(19), 2'd3, ST_OK);

		$display("*** PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire
